/* all.f */
+incdir+tb
logic/fgen_pkg.sv
logic/host_port_fsm.sv
logic/control_regs.sv
logic/wave_memory.sv
logic/playback_counter.sv
logic/fgen_top.sv
tb/tb_fgen.sv

/* tb/tb_fgen_lib.svh */
// helpers included inside tb_fgen; they use its DUT signals, wave mirror, register shadows and error count

// 32-bit linear congruential generator
function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// expected sample, lowest byte address in bits 31:24
function automatic logic [7:0] ref_byte(input int addr);
	logic [31:0] w;
	w = wave_mirror[addr / 4];
	return w[31 - 8 * (addr % 4) -: 8];
endfunction

// bits each register keeps
function automatic logic [31:0] field_mask(input logic [1:0] idx);
	case (idx)
		fgen_pkg::reg_start: return (32'd1 << byte_aw) - 1;
		fgen_pkg::reg_end: return (32'd1 << (byte_aw + 1)) - 1;
		fgen_pkg::reg_run: return 32'd1;
		default: return 32'd0;
	endcase
endfunction

task automatic report_failure(input string msg);
	$display("%s (at %0t)", msg, $time);
	error_count++;
endtask

// ----------------------------------------
// typed compares
// ----------------------------------------
task automatic check_word(input string name, input fgen_pkg::host_rsp_t got,
		input fgen_pkg::host_rsp_t exp);
	if (got !== exp) begin
		$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		error_count++;
	end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		error_count++;
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		error_count++;
	end
endtask

// ----------------------------------------
// host port
// ----------------------------------------
// one full four-phase transaction
task automatic host_txn(input fgen_pkg::opcode_t op, input logic [15:0] addr,
		input logic [31:0] data, output fgen_pkg::host_rsp_t rsp_out);
	int n;
	rsp_out = '0;
	@(negedge word_clock);
	host_cmd.opcode  = op;
	host_cmd.address = addr;
	host_cmd.data    = data;
	host_req = 1'b1;
	n = 0;
	while (host_ack !== 1'b1 && n < ack_limit) begin
		@(negedge word_clock);
		n++;
	end
	if (host_ack !== 1'b1) begin
		report_failure("host_ack never rose for the request");
	end else begin
		rsp_out = host_rsp;
		// the register changed on the same edge as ack
		if (op == fgen_pkg::op_write_reg && addr[1:0] == fgen_pkg::reg_start)
			shadow_start = data & field_mask(fgen_pkg::reg_start);
		if (op == fgen_pkg::op_write_reg && addr[1:0] == fgen_pkg::reg_end)
			shadow_end = data & field_mask(fgen_pkg::reg_end);
	end
	host_req = 1'b0;
	n = 0;
	while (host_ack !== 1'b0 && n < ack_limit) begin
		@(negedge word_clock);
		n++;
	end
	if (host_ack !== 1'b0)
		report_failure("host_ack was not released after host_req fell");
endtask

task automatic wait_sync(input int limit, output int cycles);
	cycles = 0;
	do begin
		@(negedge word_clock);
		cycles++;
	end while (sync !== 1'b1 && cycles < limit);
	if (sync !== 1'b1)
		report_failure($sformatf("no sync pulse within %0d cycles", limit));
endtask

/* tb/tb_fgen.sv */
// testbench for fgen_top with 64 wave words; memory is assumed empty and playback stopped after reset
`timescale 1ns/1ns

module tb_fgen;

	localparam int wave_words = 64;
	localparam int byte_aw    = $clog2(wave_words) + 2;
	localparam int ack_limit  = 16;
	localparam int txn_cycles = 8;
	localparam int long_pass  = 40;
	// reset, registers, wave, playback, deferred update, stop, then margin
	localparam int watchdog_cycles = 24 + 12 * txn_cycles + 128 * txn_cycles
		+ 3 * txn_cycles + 6 * long_pass + txn_cycles + 4 * long_pass
		+ txn_cycles + 3 * long_pass + 200;

	logic                word_clock;
	logic                reset3_word_clock;
	logic                host_req;
	fgen_pkg::host_cmd_t host_cmd;
	logic                host_ack;
	fgen_pkg::host_rsp_t host_rsp;
	logic [7:0]          sample;
	logic                sync;

	logic [31:0]         wave_mirror [wave_words];
	logic [31:0]         lcg_state;
	fgen_pkg::host_rsp_t rsp;
	int error_count, test_errors, tests_run, tests_failed, gap;
	// register values as written, then as seen by the counter one and two edges back
	int shadow_start, shadow_end, latch_start, latch_end, prev_start, prev_end;
	bit checking, in_pass;
	int pass_end, exp_addr;

	`include "tb_fgen_lib.svh"

	fgen_top #(
		.wave_words (wave_words)
	) uut (
		.word_clock        (word_clock),
		.reset3_word_clock (reset3_word_clock),
		.host_req          (host_req),
		.host_cmd          (host_cmd),
		.host_ack          (host_ack),
		.host_rsp          (host_rsp),
		.sample            (sample),
		.sync              (sync)
	);

	initial begin
		word_clock = 1'b0;
		forever #5 word_clock = ~word_clock;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge word_clock);
		$display("timeout: the tests did not finish in the expected number of cycles");
		$display("ERRORS FOUND");
		$finish;
	end

	always @(posedge word_clock) begin
		prev_start  <= latch_start;
		prev_end    <= latch_end;
		latch_start <= shadow_start;
		latch_end   <= shadow_end;
	end

	// ----------------------------------------
	// comparing process
	// ----------------------------------------
	always @(negedge word_clock) begin
		if (!checking) begin
			in_pass = 1'b0;
		end else if (sync === 1'b1) begin
			if (in_pass && exp_addr != pass_end)
				report_failure("sync arrived before the pass reached its end address");
			pass_end = prev_end;
			exp_addr = prev_start;
			in_pass  = 1'b1;
			check_byte("sample", sample, ref_byte(exp_addr));
			exp_addr++;
		end else if (in_pass) begin
			if (exp_addr >= pass_end) begin
				report_failure("sync missing where the pass should wrap to its start");
				in_pass = 1'b0;
			end else begin
				check_byte("sample", sample, ref_byte(exp_addr));
				exp_addr++;
			end
		end
	end

	task automatic check_quiet_outputs();
		check_flag("host_ack", host_ack, 1'b0);
		check_flag("sync", sync, 1'b0);
		check_byte("sample", sample, 8'h00);
	endtask

	task automatic reg_roundtrip(input logic [1:0] idx, input logic [31:0] data);
		host_txn(fgen_pkg::op_write_reg, idx, data, rsp);
		host_txn(fgen_pkg::op_read_reg, idx, 32'h0, rsp);
		check_word("host_rsp", rsp, data & field_mask(idx));
	endtask

	task automatic expect_passes(input int count, input int len);
		repeat (count) begin
			wait_sync(2 * long_pass + ack_limit, gap);
			if (gap != len)
				report_failure($sformatf("pass took %0d cycles instead of %0d", gap, len));
		end
	endtask

	task automatic end_test(input string name);
		if (error_count == test_errors) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, error_count - test_errors);
			tests_failed++;
		end
		test_errors = error_count;
		tests_run++;
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		reset3_word_clock = 1'b1;
		host_req  = 1'b0;
		host_cmd  = '0;
		lcg_state = 32'h3e03_3541;
		checking  = 1'b0;
		repeat (16) begin
			@(negedge word_clock);
			check_quiet_outputs();
		end
		reset3_word_clock = 1'b0;
		repeat (8) begin
			@(negedge word_clock);
			check_quiet_outputs();
		end
		end_test("reset");

		reg_roundtrip(fgen_pkg::reg_start, 32'hffff_ff10);
		reg_roundtrip(fgen_pkg::reg_end, 32'hffff_f1a0);
		reg_roundtrip(fgen_pkg::reg_run, 32'h8000_0001);
		reg_roundtrip(fgen_pkg::reg_run, 32'h0000_fffe);
		reg_roundtrip(fgen_pkg::reg_start, 32'h0);
		reg_roundtrip(fgen_pkg::reg_end, 32'h0);
		end_test("register access");

		for (int i = 0; i < wave_words; i++) begin
			lcg_state = lcg_next(lcg_state);
			wave_mirror[i] = lcg_state;
			host_txn(fgen_pkg::op_write_wave, i, lcg_state, rsp);
		end
		for (int i = 0; i < wave_words; i++) begin
			host_txn(fgen_pkg::op_read_wave, i, 32'h0, rsp);
			check_word("host_rsp", rsp, wave_mirror[i]);
		end
		end_test("wave access");

		host_txn(fgen_pkg::op_write_reg, fgen_pkg::reg_start, 32'd20, rsp);
		host_txn(fgen_pkg::op_write_reg, fgen_pkg::reg_end, 32'd60, rsp);
		checking = 1'b1;
		host_txn(fgen_pkg::op_write_reg, fgen_pkg::reg_run, 32'd1, rsp);
		wait_sync(2 * long_pass + ack_limit, gap);
		expect_passes(4, 40);
		end_test("playback");

		// shorter end lands mid-pass
		repeat (5) @(negedge word_clock);
		host_txn(fgen_pkg::op_write_reg, fgen_pkg::reg_end, 32'd40, rsp);
		wait_sync(2 * long_pass + ack_limit, gap);
		expect_passes(2, 20);
		end_test("deferred update");

		// comparator runs on falling edges, switch it off between them
		@(posedge word_clock);
		checking = 1'b0;
		host_txn(fgen_pkg::op_write_reg, fgen_pkg::reg_run, 32'd0, rsp);
		repeat (2 * long_pass) begin
			@(negedge word_clock);
			check_flag("sync", sync, 1'b0);
		end
		end_test("stop");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* logic/fgen_top.sv */
// waveform generator top; wave_words must be a power of two, sample and sync are registered and aligned
`timescale 1ns/1ns

module fgen_top #(
	parameter int wave_words = 1024
) (
	input  logic                word_clock,
	input  logic                reset3_word_clock,
	input  logic                host_req,
	input  fgen_pkg::host_cmd_t host_cmd,
	output logic                host_ack,
	output fgen_pkg::host_rsp_t host_rsp,
	output logic [7:0]          sample,
	output logic                sync
);

	localparam int word_aw = $clog2(wave_words);
	localparam int byte_aw = word_aw + 2;

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	logic               reg_write;
	logic [1:0]         reg_index;
	logic [31:0]        reg_wdata;
	logic [31:0]        reg_rdata;
	logic               wave_write;
	logic [word_aw-1:0] wave_addr;
	logic [31:0]        wave_wdata;
	logic [31:0]        wave_rdata;
	logic [byte_aw-1:0] start_addr;
	logic [byte_aw:0]   end_addr;
	logic               run;
	logic [byte_aw-1:0] play_addr;

	host_port_fsm #(
		.wave_words (wave_words)
	) host_port (
		.word_clock        (word_clock),
		.reset3_word_clock (reset3_word_clock),
		.host_req          (host_req),
		.host_cmd          (host_cmd),
		.host_ack          (host_ack),
		.host_rsp          (host_rsp),
		.reg_write         (reg_write),
		.reg_index         (reg_index),
		.reg_wdata         (reg_wdata),
		.reg_rdata         (reg_rdata),
		.wave_write        (wave_write),
		.wave_addr         (wave_addr),
		.wave_wdata        (wave_wdata),
		.wave_rdata        (wave_rdata)
	);

	control_regs #(
		.wave_words (wave_words)
	) regs (
		.word_clock        (word_clock),
		.reset3_word_clock (reset3_word_clock),
		.reg_write         (reg_write),
		.reg_index         (reg_index),
		.reg_wdata         (reg_wdata),
		.reg_rdata         (reg_rdata),
		.start_addr        (start_addr),
		.end_addr          (end_addr),
		.run               (run)
	);

	// sample comes out one cycle after play_addr
	wave_memory #(
		.wave_words (wave_words)
	) wave_mem (
		.word_clock        (word_clock),
		.reset3_word_clock (reset3_word_clock),
		.wave_write        (wave_write),
		.wave_addr         (wave_addr),
		.wave_wdata        (wave_wdata),
		.wave_rdata        (wave_rdata),
		.play_addr         (play_addr),
		.sample            (sample)
	);

	playback_counter #(
		.wave_words (wave_words)
	) playback (
		.word_clock        (word_clock),
		.reset3_word_clock (reset3_word_clock),
		.start_addr        (start_addr),
		.end_addr          (end_addr),
		.run               (run),
		.play_addr         (play_addr),
		.sync              (sync)
	);

endmodule

/* logic/playback_counter.sv */
// byte address generator from start to end-1; start/end changes apply only at a wrap or while stopped, end<=start replays start
`timescale 1ns/1ns

module playback_counter #(
	parameter int wave_words = 1024
) (
	input  logic                          word_clock,
	input  logic                          reset3_word_clock,
	input  logic [$clog2(wave_words)+1:0] start_addr,
	input  logic [$clog2(wave_words)+2:0] end_addr,
	input  logic                          run,
	output logic [$clog2(wave_words)+1:0] play_addr,
	output logic                          sync
);

	localparam int byte_aw = $clog2(wave_words) + 2;

	// copies in use for the current pass
	logic [byte_aw-1:0] active_start;
	logic [byte_aw:0]   active_end;
	logic [byte_aw:0]   last_addr;
	logic               pass_empty;
	logic               reload;
	// high while play_addr holds the first address of a pass
	logic               wrap_flag;

	assign last_addr  = active_end - 1'b1;
	assign pass_empty = active_end <= {1'b0, active_start};
	assign reload     = pass_empty || ({1'b0, play_addr} == last_addr);

	// ----------------------------------------
	// address counter
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			active_start <= '0;
			active_end   <= '0;
			play_addr    <= '0;
			wrap_flag    <= 1'b0;
		end else if (!run || reload) begin
			// stopped or at the end of a pass, pick up new limits
			active_start <= start_addr;
			active_end   <= end_addr;
			play_addr    <= start_addr;
			wrap_flag    <= 1'b1;
		end else begin
			play_addr <= play_addr + 1'b1;
			wrap_flag <= 1'b0;
		end
	end

	// delayed one cycle to line up with the registered sample
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			sync <= 1'b0;
		end else begin
			sync <= wrap_flag & run;
		end
	end

endmodule

/* logic/wave_memory.sv */
// waveform RAM, 32-bit host port and 8-bit playback port; bits 31:24 of a word play first, both reads registered
`timescale 1ns/1ns

module wave_memory #(
	parameter int wave_words = 1024
) (
	input  logic                          word_clock,
	input  logic                          reset3_word_clock,
	input  logic                          wave_write,
	input  logic [$clog2(wave_words)-1:0] wave_addr,
	input  logic [31:0]                   wave_wdata,
	output logic [31:0]                   wave_rdata,
	input  logic [$clog2(wave_words)+1:0] play_addr,
	output logic [7:0]                    sample
);

	localparam int byte_aw = $clog2(wave_words) + 2;

	logic [31:0] mem [wave_words];
	logic [31:0] play_word;
	logic [7:0]  play_byte;

	// ram contents start at zero
	initial begin
		for (int i = 0; i < wave_words; i++) begin
			mem[i] = '0;
		end
	end

	// ----------------------------------------
	// host word port
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (wave_write) begin
			mem[wave_addr] <= wave_wdata;
		end
		wave_rdata <= mem[wave_addr];
	end

	// ----------------------------------------
	// playback byte port
	// ----------------------------------------
	assign play_word = mem[play_addr[byte_aw-1:2]];

	// lowest byte address sits in the top lane
	always_comb begin
		case (play_addr[1:0])
			2'd0: play_byte = play_word[31:24];
			2'd1: play_byte = play_word[23:16];
			2'd2: play_byte = play_word[15:8];
			default: play_byte = play_word[7:0];
		endcase
	end

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			sample <= 8'd0;
		end else begin
			sample <= play_byte;
		end
	end

endmodule

/* logic/control_regs.sv */
// start, end and run registers; written values are truncated to byte address width, index 3 is not implemented
`timescale 1ns/1ns

module control_regs #(
	parameter int wave_words = 1024
) (
	input  logic                          word_clock,
	input  logic                          reset3_word_clock,
	input  logic                          reg_write,
	input  logic [1:0]                    reg_index,
	input  logic [31:0]                   reg_wdata,
	output logic [31:0]                   reg_rdata,
	output logic [$clog2(wave_words)+1:0] start_addr,
	output logic [$clog2(wave_words)+2:0] end_addr,
	output logic                          run
);

	// byte address width, four bytes per word
	localparam int byte_aw = $clog2(wave_words) + 2;

	// ----------------------------------------
	// register writes
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			start_addr <= '0;
			end_addr   <= '0;
			run        <= 1'b0;
		end else if (reg_write) begin
			case (reg_index)
				fgen_pkg::reg_start: start_addr <= reg_wdata[byte_aw-1:0];
				// end is exclusive, so it can reach the full byte count
				fgen_pkg::reg_end: end_addr <= reg_wdata[byte_aw:0];
				fgen_pkg::reg_run: run <= reg_wdata[0];
				default: begin
				end
			endcase
		end
	end

	// readback, zero-extended
	always_comb begin
		reg_rdata = '0;
		case (reg_index)
			fgen_pkg::reg_start: reg_rdata[byte_aw-1:0] = start_addr;
			fgen_pkg::reg_end: reg_rdata[byte_aw:0] = end_addr;
			fgen_pkg::reg_run: reg_rdata[0] = run;
			default: reg_rdata = '0;
		endcase
	end

endmodule

/* logic/host_port_fsm.sv */
// four-phase req/ack host port; host_cmd must hold while req is high, and req must not rise again before ack falls
`timescale 1ns/1ns

module host_port_fsm #(
	parameter int wave_words = 1024
) (
	input  logic                          word_clock,
	input  logic                          reset3_word_clock,
	input  logic                          host_req,
	input  fgen_pkg::host_cmd_t           host_cmd,
	output logic                          host_ack,
	output fgen_pkg::host_rsp_t           host_rsp,
	output logic                          reg_write,
	output logic [1:0]                    reg_index,
	output logic [31:0]                   reg_wdata,
	input  logic [31:0]                   reg_rdata,
	output logic                          wave_write,
	output logic [$clog2(wave_words)-1:0] wave_addr,
	output logic [31:0]                   wave_wdata,
	input  logic [31:0]                   wave_rdata
);

	localparam int word_aw = $clog2(wave_words);

	fgen_pkg::host_state_t state;
	fgen_pkg::opcode_t     op_q;
	logic [31:0]           wdata_q;

	// both targets see the same captured write data
	assign reg_wdata  = wdata_q;
	assign wave_wdata = wdata_q;

	// ----------------------------------------
	// control: state, ack and write strobes
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			state      <= fgen_pkg::st_idle;
			host_ack   <= 1'b0;
			reg_write  <= 1'b0;
			wave_write <= 1'b0;
		end else begin
			case (state)
				fgen_pkg::st_idle: begin
					if (host_req) begin
						// strobe goes out for exactly the access cycle
						reg_write  <= (host_cmd.opcode == fgen_pkg::op_write_reg);
						wave_write <= (host_cmd.opcode == fgen_pkg::op_write_wave);
						state      <= fgen_pkg::st_access;
					end
				end
				fgen_pkg::st_access: begin
					reg_write  <= 1'b0;
					wave_write <= 1'b0;
					if (op_q == fgen_pkg::op_read_wave) begin
						// memory output is registered, one more cycle
						state <= fgen_pkg::st_wait_read;
					end else begin
						host_ack <= 1'b1;
						state    <= fgen_pkg::st_hold_ack;
					end
				end
				fgen_pkg::st_wait_read: begin
					host_ack <= 1'b1;
					state    <= fgen_pkg::st_hold_ack;
				end
				fgen_pkg::st_hold_ack: begin
					if (!host_req) begin
						host_ack <= 1'b0;
						state    <= fgen_pkg::st_release;
					end
				end
				fgen_pkg::st_release: begin
					state <= fgen_pkg::st_idle;
				end
				default: begin
					state <= fgen_pkg::st_idle;
				end
			endcase
		end
	end

	// ----------------------------------------
	// payload: command capture and read data
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (state == fgen_pkg::st_idle && host_req) begin
			op_q      <= host_cmd.opcode;
			reg_index <= host_cmd.address[1:0];
			wave_addr <= host_cmd.address[word_aw-1:0];
			wdata_q   <= host_cmd.data;
		end
		// register bank readback is combinational
		if (state == fgen_pkg::st_access && op_q == fgen_pkg::op_read_reg) begin
			host_rsp.rdata <= reg_rdata;
		end
		if (state == fgen_pkg::st_wait_read) begin
			host_rsp.rdata <= wave_rdata;
		end
	end

endmodule

/* logic/fgen_pkg.sv */
// shared types for the waveform generator; host addresses are 16 bits, so wave_words must not exceed 65536
package fgen_pkg;

	// ----------------------------------------
	// host operations
	// ----------------------------------------
	typedef enum logic [1:0] {
		op_write_reg  = 2'd0,
		op_read_reg   = 2'd1,
		op_write_wave = 2'd2,
		op_read_wave  = 2'd3
	} opcode_t;

	// host port FSM states
	typedef enum logic [2:0] {
		st_idle      = 3'd0,
		st_access    = 3'd1,
		st_wait_read = 3'd2,
		st_hold_ack  = 3'd3,
		st_release   = 3'd4
	} host_state_t;

	// ----------------------------------------
	// host transaction payloads
	// ----------------------------------------
	// register ops use address[1:0] as the index, wave ops use it as a word address
	typedef struct packed {
		opcode_t     opcode;
		logic [15:0] address;
		logic [31:0] data;
	} host_cmd_t;

	typedef struct packed {
		logic [31:0] rdata;
	} host_rsp_t;

	// ----------------------------------------
	// register bank indices
	// ----------------------------------------
	// start and end are byte addresses, end is exclusive
	localparam logic [1:0] reg_start = 2'd0;
	localparam logic [1:0] reg_end   = 2'd1;
	localparam logic [1:0] reg_run   = 2'd2;

endpackage
